// ==== project.f ====
+incdir+verilog
verilog/fp_ex_pkg.sv
verilog/fp_ex_decode.sv
verilog/fp_noncomp.sv
verilog/fp_ex_result.sv
verilog/fp_ex_top.sv
test/fp_ex_clkgen.sv
test/fp_ex_assert.sv
test/fp_ex_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FP execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module fp_ex_tb \
  -o fp_ex_sim

./obj_dir/fp_ex_sim 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"

// ==== test/fp_ex_assert.sv ====
`timescale 1ns/10ps

module fp_ex_assert (
  input logic        clk,
  input logic        rst_n,
  input logic        op_valid_i,
  input logic        legal_i,
  input logic        valid_i,
  input logic [31:0] held_result_i,
  input logic [4:0]  held_fflags_i
);

  // Count of failed assertions
  int fail_count = 0;

  // Legal strobe shows up as valid one edge later
  legal_sets_valid: assert property (
    @(posedge clk) disable iff (!rst_n) op_valid_i && legal_i |=> valid_i
  ) else begin
    fail_count++;
    $error("result_valid low one cycle after a legal strobe");
  end

  // Illegal or unsupported strobe drops valid
  illegal_clears_valid: assert property (
    @(posedge clk) disable iff (!rst_n) op_valid_i && !legal_i |=> !valid_i
  ) else begin
    fail_count++;
    $error("result_valid high one cycle after an illegal strobe");
  end

  // Without a strobe the held outputs do not move
  idle_holds_outputs: assert property (
    @(posedge clk) disable iff (!rst_n)
    !op_valid_i |=> $stable(valid_i) && $stable(held_result_i) && $stable(held_fflags_i)
  ) else begin
    fail_count++;
    $error("held outputs changed without a strobe");
  end

endmodule

bind fp_ex_result fp_ex_assert u_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .op_valid_i    (op_valid_i),
  .legal_i       (legal_i),
  .valid_i       (result_valid_o),
  .held_result_i (result_o),
  .held_fflags_i (fflags_o)
);

// ==== test/fp_ex_clkgen.sv ====
`timescale 1ns/10ps

module fp_ex_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset held low for the first 10 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== test/fp_ex_tb.sv ====
`timescale 1ns/10ps

`include "fp_ex_params.svh"

module fp_ex_tb;

  // Tests need roughly 650 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RAND_ROUNDS    = 20;

  logic        clk;
  logic        rst_n;
  logic        op_valid;
  logic [31:0] instr;
  logic [31:0] fp_rs1;
  logic [31:0] fp_rs2;
  logic [31:0] rs1;
  logic        result_valid;
  logic [31:0] result;
  logic [4:0]  fflags;

  int check_count;
  int error_count;
  int cycle_count;

  fp_ex_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fp_ex_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid),
    .instr_i        (instr),
    .fp_rs1_i       (fp_rs1),
    .fp_rs2_i       (fp_rs2),
    .rs1_i          (rs1),
    .result_valid_o (result_valid),
    .result_o       (result),
    .fflags_o       (fflags)
  );

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // OP-FP word, register numbers do not matter to the unit
  function automatic logic [31:0] make_instr(logic [6:0] funct7, logic [4:0] rs2,
                                             logic [2:0] funct3);
    return {funct7, rs2, 5'd1, funct3, 5'd2, `FP_OPCODE_OPFP};
  endfunction

  function automatic bit is_nan(logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic bit is_snan(logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // Unsigned key in numeric order for non-NaN values, -0 below +0
  function automatic logic [31:0] order_key(logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  // Same key with both zeros equal, as IEEE compares do
  function automatic logic [31:0] value_key(logic [31:0] x);
    return (x[30:0] == 31'd0) ? 32'h8000_0000 : order_key(x);
  endfunction

  // Half special values, half random words
  function automatic logic [31:0] pick_operand();
    int k;
    k = int'($urandom % 16);
    case (k)
      0: return 32'h0000_0000;
      1: return 32'h8000_0000;
      2: return 32'h7f80_0000;
      3: return 32'hff80_0000;
      4: return `FP_CANON_NAN;
      5: return 32'h7f80_0001;
      6: return 32'hffa0_0000;
      7: return 32'h8000_0001;
      default: return $urandom;
    endcase
  endfunction

  task automatic strobe(input logic [31:0] ins, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] x);
    @(posedge clk);
    op_valid <= 1'b1;
    instr    <= ins;
    fp_rs1   <= a;
    fp_rs2   <= b;
    rs1      <= x;
  endtask

  task automatic expect_result(input string name, input logic [31:0] res, input logic nv);
    check({name, " valid"}, 32'd1, 32'(result_valid));
    check(name, res, result);
    check({name, " fflags"}, 32'({nv, 4'b0000}), 32'(fflags));
  endtask

  // One strobe, result read back after the register stage
  task automatic run_op(input string name, input logic [31:0] ins,
                        input logic [31:0] a, input logic [31:0] b, input logic [31:0] x,
                        input logic [31:0] res, input logic nv);
    strobe(ins, a, b, x);
    @(posedge clk);
    op_valid <= 1'b0;
    @(negedge clk);
    expect_result(name, res, nv);
  endtask

  task automatic illegal_op(input string name, input logic [31:0] ins);
    strobe(ins, 32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000);
    @(posedge clk);
    op_valid <= 1'b0;
    @(negedge clk);
    check({name, " valid"}, 32'd0, 32'(result_valid));
  endtask

  task automatic test_moves();
    logic [31:0] w;
    int i;
    for (i = 0; i < RAND_ROUNDS; i++) begin
      w = $urandom;
      run_op("fmv.x.w", make_instr(`FP7_FMVXW, 5'd0, `FP3_FMV), w, $urandom, 32'd0, w, 1'b0);
      w = $urandom;
      run_op("fmv.w.x", make_instr(`FP7_FMVWX, 5'd0, `FP3_FMV), 32'd0, 32'd0, w, w, 1'b0);
    end
  endtask

  task automatic test_sgnj();
    logic [31:0] a;
    logic [31:0] b;
    int i;
    for (i = 0; i < RAND_ROUNDS; i++) begin
      a = pick_operand();
      b = pick_operand();
      // Magnitude of rs1 always survives
      run_op("fsgnj", make_instr(`FP7_FSGNJ, 5'd3, `FP3_FSGNJ), a, b, 32'd0,
             {b[31], a[30:0]}, 1'b0);
      run_op("fsgnjn", make_instr(`FP7_FSGNJ, 5'd3, `FP3_FSGNJN), a, b, 32'd0,
             {~b[31], a[30:0]}, 1'b0);
      run_op("fsgnjx", make_instr(`FP7_FSGNJ, 5'd3, `FP3_FSGNJX), a, b, 32'd0,
             {a[31] ^ b[31], a[30:0]}, 1'b0);
    end
  endtask

  task automatic minmax_pair(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        nv;
    nv = is_snan(a) || is_snan(b);
    if (is_nan(a) && is_nan(b)) begin
      lo = `FP_CANON_NAN;
      hi = `FP_CANON_NAN;
    end else if (is_nan(a)) begin
      lo = b;
      hi = b;
    end else if (is_nan(b)) begin
      lo = a;
      hi = a;
    end else if (order_key(a) < order_key(b)) begin
      lo = a;
      hi = b;
    end else begin
      lo = b;
      hi = a;
    end
    run_op("fmin", make_instr(`FP7_FMINMAX, 5'd3, `FP3_FMIN), a, b, 32'd0, lo, nv);
    run_op("fmax", make_instr(`FP7_FMINMAX, 5'd3, `FP3_FMAX), a, b, 32'd0, hi, nv);
  endtask

  task automatic test_minmax();
    int i;
    // Signed zeros, -0 is the smaller one
    run_op("fmin zeros", make_instr(`FP7_FMINMAX, 5'd3, `FP3_FMIN),
           32'h0000_0000, 32'h8000_0000, 32'd0, 32'h8000_0000, 1'b0);
    run_op("fmax zeros", make_instr(`FP7_FMINMAX, 5'd3, `FP3_FMAX),
           32'h8000_0000, 32'h0000_0000, 32'd0, 32'h0000_0000, 1'b0);
    // Two NaNs, one signalling
    run_op("fmax nans", make_instr(`FP7_FMINMAX, 5'd3, `FP3_FMAX),
           32'h7fc1_2345, 32'hff80_0001, 32'd0, `FP_CANON_NAN, 1'b1);
    minmax_pair(`FP_CANON_NAN, 32'h3f80_0000);
    minmax_pair(32'hbf80_0000, 32'h7f80_0001);
    minmax_pair(32'h7fc0_0000, 32'hffc0_0000);
    for (i = 0; i < RAND_ROUNDS; i++) begin
      minmax_pair(pick_operand(), pick_operand());
    end
  endtask

  task automatic cmp_pair(input logic [31:0] a, input logic [31:0] b);
    bit any_nan;
    bit any_snan;
    any_nan  = is_nan(a) || is_nan(b);
    any_snan = is_snan(a) || is_snan(b);
    // FEQ is quiet, FLT and FLE signal on any NaN
    run_op("feq", make_instr(`FP7_FCMP, 5'd3, `FP3_FEQ), a, b, 32'd0,
           32'(!any_nan && (value_key(a) == value_key(b))), any_snan);
    run_op("flt", make_instr(`FP7_FCMP, 5'd3, `FP3_FLT), a, b, 32'd0,
           32'(!any_nan && (value_key(a) < value_key(b))), any_nan);
    run_op("fle", make_instr(`FP7_FCMP, 5'd3, `FP3_FLE), a, b, 32'd0,
           32'(!any_nan && (value_key(a) <= value_key(b))), any_nan);
  endtask

  task automatic test_cmp();
    logic [31:0] a;
    int i;
    cmp_pair(32'h0000_0000, 32'h8000_0000);
    cmp_pair(32'h3f80_0000, 32'h3f80_0000);
    cmp_pair(32'hbf80_0000, 32'h3f80_0000);
    cmp_pair(32'h3f80_0000, 32'hbf80_0000);
    cmp_pair(`FP_CANON_NAN, 32'h3f80_0000);
    cmp_pair(32'h3f80_0000, 32'h7f80_0001);
    cmp_pair(32'hff80_0000, 32'h7f80_0000);
    cmp_pair(32'h0000_0001, 32'h8000_0001);
    for (i = 0; i < RAND_ROUNDS; i++) begin
      a = pick_operand();
      cmp_pair(a, pick_operand());
      // Equal operands now and then
      if (i % 4 == 0) begin
        cmp_pair(a, a);
      end
    end
  endtask

  task automatic class_one(input logic [31:0] x, input int idx);
    run_op("fclass", make_instr(`FP7_FMVXW, 5'd0, `FP3_FCLASS), x, 32'd0, 32'd0,
           32'd1 << idx, 1'b0);
  endtask

  task automatic test_class();
    class_one(32'hff80_0000, `FCLASS_NEG_INF);
    class_one(32'hbf80_0000, `FCLASS_NEG_NORM);
    class_one(32'h807f_ffff, `FCLASS_NEG_SUB);
    class_one(32'h8000_0000, `FCLASS_NEG_ZERO);
    class_one(32'h0000_0000, `FCLASS_POS_ZERO);
    class_one(32'h0000_0001, `FCLASS_POS_SUB);
    class_one(32'h3f80_0000, `FCLASS_POS_NORM);
    class_one(32'h7f80_0000, `FCLASS_POS_INF);
    class_one(32'h7f80_0001, `FCLASS_SNAN);
    class_one(32'h7fc0_0000, `FCLASS_QNAN);
  endtask

  task automatic test_hold_illegal();
    int i;
    run_op("hold", make_instr(`FP7_FMVWX, 5'd0, `FP3_FMV), 32'd0, 32'd0,
           32'h1234_5678, 32'h1234_5678, 1'b0);
    for (i = 0; i < 5; i++) begin
      @(negedge clk);
      expect_result("hold idle", 32'h1234_5678, 1'b0);
    end
    // FADD.S is funct7 zero, not handled here
    illegal_op("fadd", make_instr(7'b0000000, 5'd3, 3'b000));
    illegal_op("fmv.x.w bad funct3", make_instr(`FP7_FMVXW, 5'd0, 3'b010));
    // Three strobes in a row, each result one cycle after its strobe
    strobe(make_instr(`FP7_FMVWX, 5'd0, `FP3_FMV), 32'd0, 32'd0, 32'haaaa_0001);
    strobe(make_instr(`FP7_FSGNJ, 5'd3, `FP3_FSGNJN), 32'h3f80_0000, 32'h3f80_0000, 32'd0);
    @(negedge clk);
    expect_result("b2b first", 32'haaaa_0001, 1'b0);
    strobe(make_instr(`FP7_FMINMAX, 5'd3, `FP3_FMIN), 32'h7f80_0001, 32'h4000_0000, 32'd0);
    @(negedge clk);
    expect_result("b2b second", 32'hbf80_0000, 1'b0);
    @(posedge clk);
    op_valid <= 1'b0;
    @(negedge clk);
    expect_result("b2b third", 32'h4000_0000, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h01e9b391));
    check_count = 0;
    error_count = 0;
    op_valid    = 1'b0;
    instr       = 32'd0;
    fp_rs1      = 32'd0;
    fp_rs2      = 32'd0;
    rs1         = 32'd0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check("reset valid", 32'd0, 32'(result_valid));
    check("reset result", 32'd0, result);
    check("reset fflags", 32'd0, 32'(fflags));
    test_moves();
    test_sgnj();
    test_minmax();
    test_cmp();
    test_class();
    test_hold_illegal();
    @(negedge clk);
    $display("checks %0d, mismatches %0d, assertion failures %0d",
             check_count, error_count, dut0.u_result.u_assert.fail_count);
    if (error_count == 0 && dut0.u_result.u_assert.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Cycle counter that ends a stuck run
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verilog/fp_ex_decode.sv ====
`timescale 1ns/10ps

`include "fp_ex_params.svh"

module fp_ex_decode (
  input  logic [31:0]       instr_i,
  output fp_ex_pkg::fp_op_e op_o,
  output logic [2:0]        sub_op_o,
  output logic              legal_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rs2_field;
  logic [6:0] funct7;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign rs2_field = instr_i[24:20];
  assign funct7    = instr_i[31:25];

  // funct3 goes straight through as the sub-operation
  assign sub_op_o = funct3;

  always_comb begin
    // Anything not matched below stays illegal
    op_o    = fp_ex_pkg::NONE;
    legal_o = 1'b0;

    // FMA opcodes and the arithmetic funct7 groups never match here
    if (opcode == `FP_OPCODE_OPFP) begin
      case (funct7)
        `FP7_FSGNJ: begin
          if (funct3 == `FP3_FSGNJ || funct3 == `FP3_FSGNJN ||
              funct3 == `FP3_FSGNJX) begin
            op_o    = fp_ex_pkg::FSGNJ;
            legal_o = 1'b1;
          end
        end
        `FP7_FMINMAX: begin
          if (funct3 == `FP3_FMIN || funct3 == `FP3_FMAX) begin
            op_o    = fp_ex_pkg::MINMAX;
            legal_o = 1'b1;
          end
        end
        `FP7_FCMP: begin
          if (funct3 == `FP3_FEQ || funct3 == `FP3_FLT || funct3 == `FP3_FLE) begin
            op_o    = fp_ex_pkg::CMP;
            legal_o = 1'b1;
          end
        end
        `FP7_FMVXW: begin
          // Shared funct7, funct3 picks FMV.X.W or FCLASS
          // Single-source forms need rs2 = 0
          if (rs2_field == 5'd0) begin
            if (funct3 == `FP3_FMV) begin
              op_o    = fp_ex_pkg::MV_X_W;
              legal_o = 1'b1;
            end else if (funct3 == `FP3_FCLASS) begin
              op_o    = fp_ex_pkg::CLASS;
              legal_o = 1'b1;
            end
          end
        end
        `FP7_FMVWX: begin
          if (rs2_field == 5'd0 && funct3 == `FP3_FMV) begin
            op_o    = fp_ex_pkg::MV_W_X;
            legal_o = 1'b1;
          end
        end
        default: begin
          // FADD, FMUL, FCVT and friends fall through as NONE
          op_o    = fp_ex_pkg::NONE;
          legal_o = 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== verilog/fp_ex_params.svh ====
`ifndef FP_EX_PARAMS_SVH
`define FP_EX_PARAMS_SVH

// Major opcode shared by every single-precision OP-FP instruction
`define FP_OPCODE_OPFP 7'b1010011

// funct7 groups with fmt = S in the low two bits
`define FP7_FSGNJ      7'b0010000
`define FP7_FMINMAX    7'b0010100
`define FP7_FCMP       7'b1010000
`define FP7_FMVXW      7'b1110000
`define FP7_FMVWX      7'b1111000

// funct3 values inside each group
`define FP3_FMV        3'b000
`define FP3_FCLASS     3'b001
`define FP3_FSGNJ      3'b000
`define FP3_FSGNJN     3'b001
`define FP3_FSGNJX     3'b010
`define FP3_FMIN       3'b000
`define FP3_FMAX       3'b001
`define FP3_FLE        3'b000
`define FP3_FLT        3'b001
`define FP3_FEQ        3'b010

// Quiet NaN returned when both min/max inputs are NaN
`define FP_CANON_NAN   32'h7fc00000

// One-hot FCLASS result bit positions
`define FCLASS_NEG_INF  0
`define FCLASS_NEG_NORM 1
`define FCLASS_NEG_SUB  2
`define FCLASS_NEG_ZERO 3
`define FCLASS_POS_ZERO 4
`define FCLASS_POS_SUB  5
`define FCLASS_POS_NORM 6
`define FCLASS_POS_INF  7
`define FCLASS_SNAN     8
`define FCLASS_QNAN     9

`endif

// ==== verilog/fp_ex_pkg.sv ====
package fp_ex_pkg;

  // Operation classes handled by the non-computational datapath
  // NONE covers illegal encodings and every rounding operation
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    FSGNJ  = 3'd1,
    MINMAX = 3'd2,
    CMP    = 3'd3,
    CLASS  = 3'd4,
    MV_X_W = 3'd5,
    MV_W_X = 3'd6
  } fp_op_e;

  // One 32-bit register word seen in two ways
  // f splits out the IEEE single-precision fields
  // raw is the plain bit pattern for moves and the result bus
  typedef union packed {
    struct packed {
      // Sign bit, 1 means negative
      logic        sign;
      // Biased exponent
      logic [7:0]  exp;
      // Fraction without the hidden bit
      logic [22:0] man;
    } f;
    logic [31:0] raw;
  } fp_word_u;

endpackage

// ==== verilog/fp_ex_result.sv ====
`timescale 1ns/10ps

module fp_ex_result (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        op_valid_i,
  input  logic        legal_i,
  input  logic [31:0] result_i,
  input  logic        nv_i,
  output logic        result_valid_o,
  output logic [31:0] result_o,
  output logic [4:0]  fflags_o
);

  logic        valid_q;
  logic [31:0] result_q;
  logic [4:0]  fflags_q;

  // Capture on every strobe, hold until the next one
  // A strobe with an illegal op drops valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= 1'b0;
      result_q <= '0;
      fflags_q <= '0;
    end else if (op_valid_i) begin
      valid_q  <= legal_i;
      result_q <= result_i;
      // Flag order {NV, DZ, OF, UF, NX}
      // Nothing here rounds or divides, so only NV can fire
      fflags_q <= {nv_i, 4'b0000};
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;
  assign fflags_o       = fflags_q;

endmodule

// ==== verilog/fp_ex_top.sv ====
`timescale 1ns/10ps

module fp_ex_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        op_valid_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] fp_rs1_i,
  input  logic [31:0] fp_rs2_i,
  input  logic [31:0] rs1_i,
  output logic        result_valid_o,
  output logic [31:0] result_o,
  output logic [4:0]  fflags_o
);

  // Decode outputs
  fp_ex_pkg::fp_op_e op;
  logic [2:0]        sub_op;
  logic              legal;

  // Combinational datapath outputs
  logic [31:0]       nc_result;
  logic              nc_nv;

  fp_ex_decode u_decode (
    .instr_i  (instr_i),
    .op_o     (op),
    .sub_op_o (sub_op),
    .legal_o  (legal)
  );

  fp_noncomp u_noncomp (
    .op_i     (op),
    .sub_op_i (sub_op),
    .fp_rs1_i (fp_rs1_i),
    .fp_rs2_i (fp_rs2_i),
    .rs1_i    (rs1_i),
    .result_o (nc_result),
    .nv_o     (nc_nv)
  );

  // One register stage between datapath and EX stage
  fp_ex_result u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid_i),
    .legal_i        (legal),
    .result_i       (nc_result),
    .nv_i           (nc_nv),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .fflags_o       (fflags_o)
  );

endmodule

// ==== verilog/fp_noncomp.sv ====
`timescale 1ns/10ps

`include "fp_ex_params.svh"

module fp_noncomp (
  input  fp_ex_pkg::fp_op_e op_i,
  input  logic [2:0]        sub_op_i,
  input  logic [31:0]       fp_rs1_i,
  input  logic [31:0]       fp_rs2_i,
  input  logic [31:0]       rs1_i,
  output logic [31:0]       result_o,
  output logic              nv_o
);

  // Per-word class flags, returned as {snan, qnan, inf, sub, zero}
  function automatic logic [4:0] word_flags(fp_ex_pkg::fp_word_u w);
    logic exp_max;
    logic exp_zero;
    logic man_zero;
    exp_max  = &w.f.exp;
    exp_zero = ~|w.f.exp;
    man_zero = ~|w.f.man;
    // Quiet NaN has the top fraction bit set
    return {exp_max & ~man_zero & ~w.f.man[22],
            exp_max & ~man_zero & w.f.man[22],
            exp_max & man_zero,
            exp_zero & ~man_zero,
            exp_zero & man_zero};
  endfunction

  fp_ex_pkg::fp_word_u a;
  fp_ex_pkg::fp_word_u b;

  assign a = fp_rs1_i;
  assign b = fp_rs2_i;

  logic a_snan, a_qnan, a_inf, a_sub, a_zero, a_nan;
  logic b_snan, b_qnan, b_inf, b_sub, b_zero, b_nan;

  assign {a_snan, a_qnan, a_inf, a_sub, a_zero} = word_flags(a);
  assign {b_snan, b_qnan, b_inf, b_sub, b_zero} = word_flags(b);
  assign a_nan = a_snan | a_qnan;
  assign b_nan = b_snan | b_qnan;

  // Ordering of two non-NaN operands
  // lt_total puts -0 below +0, lt_ieee treats the two zeros as equal
  logic both_zero;
  logic mag_lt;
  logic mag_gt;
  logic lt_total;
  logic lt_ieee;
  logic eq_ieee;

  assign both_zero = a_zero & b_zero;
  assign mag_lt    = a.raw[30:0] < b.raw[30:0];
  assign mag_gt    = b.raw[30:0] < a.raw[30:0];
  // Sign-magnitude order, larger magnitude is smaller when negative
  assign lt_total  = (a.f.sign != b.f.sign) ? a.f.sign :
                     (a.f.sign ? mag_gt : mag_lt);
  assign lt_ieee   = lt_total & ~both_zero;
  assign eq_ieee   = (a.raw == b.raw) | both_zero;

  // Sign injection keeps the rs1 magnitude
  logic sgnj_sign;

  always_comb begin
    case (sub_op_i)
      `FP3_FSGNJN: sgnj_sign = ~b.f.sign;
      `FP3_FSGNJX: sgnj_sign = a.f.sign ^ b.f.sign;
      default:     sgnj_sign = b.f.sign;
    endcase
  end

  // Min/max with NaN propagation rules
  logic [31:0] minmax_res;

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_res = `FP_CANON_NAN;
    end else if (a_nan) begin
      minmax_res = b.raw;
    end else if (b_nan) begin
      minmax_res = a.raw;
    end else if (sub_op_i == `FP3_FMAX) begin
      minmax_res = lt_total ? b.raw : a.raw;
    end else begin
      minmax_res = lt_total ? a.raw : b.raw;
    end
  end

  // Compares, any NaN forces 0
  logic cmp_res;
  logic cmp_nv;

  always_comb begin
    case (sub_op_i)
      `FP3_FEQ: begin
        // Quiet compare, only sNaN signals
        cmp_res = ~(a_nan | b_nan) & eq_ieee;
        cmp_nv  = a_snan | b_snan;
      end
      `FP3_FLT: begin
        cmp_res = ~(a_nan | b_nan) & lt_ieee;
        cmp_nv  = a_nan | b_nan;
      end
      default: begin
        // FLE, decode passes no other funct3 here
        cmp_res = ~(a_nan | b_nan) & (lt_ieee | eq_ieee);
        cmp_nv  = a_nan | b_nan;
      end
    endcase
  end

  // FCLASS one-hot mask of rs1
  logic [9:0] class_mask;

  always_comb begin
    class_mask = '0;
    if (a_snan) begin
      class_mask[`FCLASS_SNAN] = 1'b1;
    end else if (a_qnan) begin
      class_mask[`FCLASS_QNAN] = 1'b1;
    end else if (a_inf) begin
      class_mask[a.f.sign ? `FCLASS_NEG_INF : `FCLASS_POS_INF] = 1'b1;
    end else if (a_zero) begin
      class_mask[a.f.sign ? `FCLASS_NEG_ZERO : `FCLASS_POS_ZERO] = 1'b1;
    end else if (a_sub) begin
      class_mask[a.f.sign ? `FCLASS_NEG_SUB : `FCLASS_POS_SUB] = 1'b1;
    end else begin
      class_mask[a.f.sign ? `FCLASS_NEG_NORM : `FCLASS_POS_NORM] = 1'b1;
    end
  end

  // Final result select
  always_comb begin
    result_o = '0;
    nv_o     = 1'b0;
    case (op_i)
      fp_ex_pkg::FSGNJ:  result_o = {sgnj_sign, a.raw[30:0]};
      fp_ex_pkg::MINMAX: begin
        result_o = minmax_res;
        nv_o     = a_snan | b_snan;
      end
      fp_ex_pkg::CMP: begin
        result_o = {31'd0, cmp_res};
        nv_o     = cmp_nv;
      end
      fp_ex_pkg::CLASS:  result_o = {22'd0, class_mask};
      // Moves copy bits unchanged, no flags
      fp_ex_pkg::MV_X_W: result_o = a.raw;
      fp_ex_pkg::MV_W_X: result_o = rs1_i;
      default:           result_o = '0;
    endcase
  end

endmodule
